// File: mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

////////////////////////////////////////////////////////////
// Data memory geometry
////////////////////////////////////////////////////////////

// Word-address bits of the data memory
// 8 bits give 256 words of 32 bits
`define MEM_ADDR_W 8

// Depth in 32-bit words, follows the address width
`define MEM_WORDS (1 << `MEM_ADDR_W)

`endif

// File: mem_stage_pkg.sv
`default_nettype none

package mem_stage_pkg;

  // Load operation, LD_NONE for anything that is not a load
  typedef enum logic [2:0] {
    LD_NONE = 3'd0,
    LD_LB   = 3'd1,
    LD_LH   = 3'd2,
    LD_LW   = 3'd3,
    LD_LBU  = 3'd4,
    LD_LHU  = 3'd5
  } load_op_e;

  // Store operation, ST_NONE for anything that is not a store
  typedef enum logic [1:0] {
    ST_NONE = 2'd0,
    ST_SB   = 2'd1,
    ST_SH   = 2'd2,
    ST_SW   = 2'd3
  } store_op_e;

  // Record from the execute stage
  typedef struct packed {
    logic        valid;
    logic [31:0] alures;    // Effective address or ALU result
    logic [31:0] rs2_data;  // Store data as read in decode
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        regwrite;
    logic        memread;
    logic        memwrite;
    load_op_e    load_op;
    store_op_e   store_op;
  } ex_mem_t;

  // Request into the data memory
  typedef struct packed {
    logic        en;     // Port enable, read happens on every enabled cycle
    logic        we;     // Write strobe
    logic [3:0]  be;     // Byte lane enables
    logic [31:0] addr;   // Word address, upper bits dropped by the memory
    logic [31:0] wdata;  // Lane-aligned write data
  } ram_req_t;

  // Record towards writeback
  typedef struct packed {
    logic        valid;
    logic        regwrite;
    logic        memread;
    logic [4:0]  rd;
    logic [31:0] alures;
    logic [31:0] memres;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: store_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module store_unit (
  input  mem_stage_pkg::ex_mem_t  ex_mem,
  input  mem_stage_pkg::mem_wb_t  mem_wb,
  input  logic [31:0]             wb_res,
  input  logic                    hold,
  output mem_stage_pkg::ram_req_t ram_req
);

  import mem_stage_pkg::*;

  logic [1:0]  offset;
  logic [3:0]  be;
  logic        fwd;
  logic [31:0] st_data;
  logic [31:0] lane_data;
  logic        access;

  // Byte offset inside the addressed word
  assign offset = ex_mem.alures[1:0];

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  // sh at offset 3 wraps into lane 0, no misalignment trap
  always_comb begin
    unique case (ex_mem.store_op)
      ST_SB:   be = 4'b0001 << offset;
      ST_SH: begin
        unique case (offset)
          2'd0: be = 4'b0011;
          2'd1: be = 4'b0110;
          2'd2: be = 4'b1100;
          2'd3: be = 4'b1001;
        endcase
      end
      ST_SW:   be = 4'b1111;
      default: be = 4'b0000;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Store data forwarding and lane rotation
  ////////////////////////////////////////////////////////////

  // Writeback is about to update rs2, take its value instead
  assign fwd = ex_mem.valid && ex_mem.memwrite && mem_wb.regwrite &&
               (mem_wb.rd == ex_mem.rs2);
  assign st_data = fwd ? wb_res : ex_mem.rs2_data;

  // Rotate left by 8 x offset so byte 0 lands in the addressed lane
  always_comb begin
    unique case (offset)
      2'd0: lane_data = st_data;
      2'd1: lane_data = {st_data[23:0], st_data[31:24]};
      2'd2: lane_data = {st_data[15:0], st_data[31:16]};
      2'd3: lane_data = {st_data[7:0], st_data[31:8]};
    endcase
  end

  // Memory access only for a valid load or store, never under hold
  assign access = ex_mem.valid && (ex_mem.memread || ex_mem.memwrite) && !hold;

  always_comb begin
    ram_req.en    = access;
    ram_req.we    = access && ex_mem.memwrite;
    ram_req.be    = be;
    // Word address, bits above the memory depth forced to zero
    ram_req.addr  = {{(32 - `MEM_ADDR_W){1'b0}}, ex_mem.alures[`MEM_ADDR_W+1:2]};
    ram_req.wdata = lane_data;
  end

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module data_ram (
  input  logic                    bus,
  input  mem_stage_pkg::ram_req_t ram_req,
  output logic [31:0]             rdata
);

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  // Block RAM style word array, contents undefined after power-up
  logic [31:0] mem [`MEM_WORDS];

  // Index into the array
  logic [`MEM_ADDR_W-1:0] word_addr;

  // Upper request address bits fall outside the memory
  assign word_addr = ram_req.addr[`MEM_ADDR_W-1:0];

  ////////////////////////////////////////////////////////////
  // Single port, byte-enabled write and registered read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (ram_req.en) begin
      // Per-lane write
      for (int i = 0; i < 4; i++) begin
        if (ram_req.we && ram_req.be[i]) begin
          mem[word_addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
        end
      end
      // Read-first, a same-address write returns the old word
      rdata <= mem[word_addr];
    end
    // Disabled cycles keep the last read word
  end

endmodule

`default_nettype wire

// File: load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit (
  input  logic                   bus,
  input  logic                   rst_n,
  input  logic                   hold,
  input  mem_stage_pkg::ex_mem_t ex_mem,
  input  logic [31:0]            rdata,
  output mem_stage_pkg::mem_wb_t mem_wb
);

  import mem_stage_pkg::*;

  logic        valid_q;
  logic        regwrite_q;
  logic        memread_q;
  logic [4:0]  rd_q;
  logic [31:0] alures_q;
  load_op_e    load_op_q;
  logic [1:0]  offset_q;
  logic [31:0] rot_data;
  logic [31:0] memres;

  ////////////////////////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////////////////////////

  // Hold freezes the stage and drops the incoming record
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= 1'b0;
      regwrite_q <= 1'b0;
      memread_q  <= 1'b0;
      rd_q       <= 5'd0;
      alures_q   <= 32'd0;
      load_op_q  <= LD_NONE;
      offset_q   <= 2'd0;
    end else if (!hold) begin
      valid_q    <= ex_mem.valid;
      // Control bits only count for a valid record
      regwrite_q <= ex_mem.valid && ex_mem.regwrite;
      memread_q  <= ex_mem.valid && ex_mem.memread;
      rd_q       <= ex_mem.rd;
      alures_q   <= ex_mem.alures;
      // No load selection unless a real load went to memory
      load_op_q  <= (ex_mem.valid && ex_mem.memread) ? ex_mem.load_op : LD_NONE;
      offset_q   <= ex_mem.alures[1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Load lane select and extension
  ////////////////////////////////////////////////////////////

  // Bring the addressed byte down to lane 0
  always_comb begin
    unique case (offset_q)
      2'd0: rot_data = rdata;
      2'd1: rot_data = {rdata[7:0], rdata[31:8]};
      2'd2: rot_data = {rdata[15:0], rdata[31:16]};
      2'd3: rot_data = {rdata[23:0], rdata[31:24]};
    endcase
  end

  always_comb begin
    unique case (load_op_q)
      LD_LB:   memres = {{24{rot_data[7]}}, rot_data[7:0]};
      LD_LH:   memres = {{16{rot_data[15]}}, rot_data[15:0]};
      LD_LW:   memres = rot_data;
      LD_LBU:  memres = {24'd0, rot_data[7:0]};
      LD_LHU:  memres = {16'd0, rot_data[15:0]};
      default: memres = 32'd0;
    endcase
  end

  // Record towards writeback
  always_comb begin
    mem_wb.valid    = valid_q;
    mem_wb.regwrite = regwrite_q;
    mem_wb.memread  = memread_q;
    mem_wb.rd       = rd_q;
    mem_wb.alures   = alures_q;
    mem_wb.memres   = memres;
  end

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                   bus,
  input  logic                   rst_n,
  input  logic                   hold,
  input  mem_stage_pkg::ex_mem_t ex_mem,
  input  logic [31:0]            wb_res,
  output mem_stage_pkg::mem_wb_t mem_wb
);

  import mem_stage_pkg::*;

  // Request from the store unit into the data memory
  ram_req_t    ram_req;
  // Registered read word, one cycle after the request
  logic [31:0] rdata;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Registered mem_wb feeds back for store data forwarding
  store_unit store_unit_i (
    .ex_mem  (ex_mem),
    .mem_wb  (mem_wb),
    .wb_res  (wb_res),
    .hold    (hold),
    .ram_req (ram_req)
  );

  data_ram data_ram_i (
    .bus     (bus),
    .ram_req (ram_req),
    .rdata   (rdata)
  );

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  load_unit load_unit_i (
    .bus    (bus),
    .rst_n  (rst_n),
    .hold   (hold),
    .ex_mem (ex_mem),
    .rdata  (rdata),
    .mem_wb (mem_wb)
  );

endmodule

`default_nettype wire

// File: mem_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_props (
  input wire logic                   bus,
  input wire logic                   rst_n,
  input wire logic                   hold,
  input wire mem_stage_pkg::mem_wb_t mem_wb
);

  import mem_stage_pkg::*;

  // Failed assertion count, polled by the testbench
  int fail_count;

  ////////////////////////////////////////////////////////////
  // MEM/WB record properties
  ////////////////////////////////////////////////////////////

  // Record clear by the clock after reset is seen low
  reset_clear: assert property (@(posedge bus) !rst_n |=> (mem_wb == '0))
    else begin
      $error("mem_wb not cleared during reset");
      fail_count++;
    end

  // Hold freezes the whole record, memres included
  hold_frozen: assert property (@(posedge bus) disable iff (!rst_n) hold |=> $stable(mem_wb))
    else begin
      $error("mem_wb changed while hold was high");
      fail_count++;
    end

  // Control bits only on a valid record
  ctrl_needs_valid: assert property (@(posedge bus) disable iff (!rst_n)
    (mem_wb.memread || mem_wb.regwrite) |-> mem_wb.valid)
    else begin
      $error("memread or regwrite set without valid");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: mem_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage_tb;

  import mem_stage_pkg::*;

  typedef struct {
    logic        hold;
    ex_mem_t     em;
    logic [31:0] wb_res;
    mem_wb_t     exp;
  } row_t;

  logic        bus;
  logic        rst_n;
  logic        hold;
  ex_mem_t     ex_mem;
  logic [31:0] wb_res;
  mem_wb_t     mem_wb;

  row_t        rows[$];
  // Byte-wide reference memory, same depth as the DUT array
  logic [7:0]  ref_mem [`MEM_WORDS*4];
  mem_wb_t     last_exp;
  int          seed;

  mem_stage mem_stage_i (
    .bus    (bus),
    .rst_n  (rst_n),
    .hold   (hold),
    .ex_mem (ex_mem),
    .wb_res (wb_res),
    .mem_wb (mem_wb)
  );

  bind load_unit mem_stage_props props_i (
    .bus(bus), .rst_n(rst_n), .hold(hold), .mem_wb(mem_wb)
  );

  always #2 bus = ~bus;

  ////////////////////////////////////////////////////////////
  // Clock edges and checks
  ////////////////////////////////////////////////////////////

  // Falling edge, bounded by a count of clock toggles
  task automatic next_fall();
    int toggles;
    logic fell;
    toggles = 0;
    fell = 1'b0;
    while (!fell && toggles < 8) begin
      @(bus);
      toggles++;
      if (bus === 1'b0) fell = 1'b1;
    end
    if (!fell) begin
      $display("Timeout: the clock stopped toggling");
      $display("=== FAIL ===");
      $fatal(1, "clock timeout");
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_mem_wb(input mem_wb_t got, input mem_wb_t exp);
    if (got !== exp) begin
      $display("[FAIL] mem_wb got %h expected %h", got, exp);
      $display("=== FAIL ===");
      $fatal(1, "record mismatch");
    end
  endtask

  // Bound assertions on the MEM/WB record
  task automatic verify_assertions();
    if (mem_stage_i.load_unit_i.props_i.fail_count != 0) begin
      $display("A bound assertion on the MEM/WB record failed");
      $display("=== FAIL ===");
      $fatal(1, "assertion failure");
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Byte k of the lane-rotated word sits in lane (offset + k) mod 4
  function automatic logic [31:0] model_load(input load_op_e op, input logic [31:0] addr);
    logic [31:0] w;
    logic [1:0]  lane;
    for (int k = 0; k < 4; k++) begin
      lane = addr[1:0] + k[1:0];
      w[8*k +: 8] = ref_mem[{addr[`MEM_ADDR_W+1:2], lane}];
    end
    case (op)
      LD_LB:   return {{24{w[7]}}, w[7:0]};
      LD_LH:   return {{16{w[15]}}, w[15:0]};
      LD_LW:   return w;
      LD_LBU:  return {24'd0, w[7:0]};
      LD_LHU:  return {16'd0, w[15:0]};
      default: return 32'd0;
    endcase
  endfunction

  task automatic model_store(input store_op_e op, input logic [31:0] addr, input logic [31:0] d);
    int nbytes;
    logic [1:0] lane;
    nbytes = (op == ST_SB) ? 1 : (op == ST_SH) ? 2 : (op == ST_SW) ? 4 : 0;
    for (int k = 0; k < nbytes; k++) begin
      lane = addr[1:0] + k[1:0];
      ref_mem[{addr[`MEM_ADDR_W+1:2], lane}] = d[8*k +: 8];
    end
  endtask

  // Appends a row and derives its expected MEM/WB record
  task automatic push_row(input logic h, input ex_mem_t em, input logic [31:0] wb);
    row_t r;
    logic fwd;
    r.hold = h;
    r.em = em;
    r.wb_res = wb;
    if (h) begin
      r.exp = last_exp;
    end else begin
      fwd = em.valid && em.memwrite && last_exp.regwrite && (last_exp.rd == em.rs2);
      r.exp = '0;
      r.exp.valid = em.valid;
      r.exp.regwrite = em.valid && em.regwrite;
      r.exp.memread = em.valid && em.memread;
      r.exp.rd = em.rd;
      r.exp.alures = em.alures;
      if (em.valid && em.memread) r.exp.memres = model_load(em.load_op, em.alures);
      if (em.valid && em.memwrite) model_store(em.store_op, em.alures, fwd ? wb : em.rs2_data);
      last_exp = r.exp;
    end
    rows.push_back(r);
  endtask

  task automatic add_alu(input logic [4:0] rd, input logic [31:0] val);
    ex_mem_t em;
    em = '0;
    em.valid = 1'b1;
    em.regwrite = 1'b1;
    em.rd = rd;
    em.alures = val;
    push_row(1'b0, em, 32'd0);
  endtask

  task automatic add_store(input store_op_e op, input logic [31:0] addr, input logic [31:0] d,
                           input logic [4:0] rs2, input logic [31:0] wb, input logic h);
    ex_mem_t em;
    em = '0;
    em.valid = 1'b1;
    em.memwrite = 1'b1;
    em.store_op = op;
    em.alures = addr;
    em.rs2_data = d;
    em.rs2 = rs2;
    push_row(h, em, wb);
  endtask

  task automatic add_load(input load_op_e op, input logic [31:0] addr, input logic [4:0] rd);
    ex_mem_t em;
    em = '0;
    em.valid = 1'b1;
    em.memread = 1'b1;
    em.regwrite = 1'b1;
    em.load_op = op;
    em.alures = addr;
    em.rd = rd;
    push_row(1'b0, em, 32'd0);
  endtask

  // Invalid record that still carries load, store and writeback bits
  task automatic add_bubble(input logic [31:0] addr, input logic [31:0] d, input logic [4:0] rd);
    ex_mem_t em;
    em = '0;
    em.regwrite = 1'b1;
    em.memread = 1'b1;
    em.memwrite = 1'b1;
    em.load_op = LD_LW;
    em.store_op = ST_SW;
    em.alures = addr;
    em.rs2_data = d;
    em.rd = rd;
    push_row(1'b0, em, 32'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic build_table();
    load_op_e ops[4];
    ops = '{LD_LB, LD_LBU, LD_LH, LD_LHU};
    // Pass-through and word round trip
    add_alu(5'd1, 32'h1234_5678);
    add_store(ST_SW, 32'h40, $random(seed), 5'd0, 32'd0, 1'b0);
    add_load(LD_LW, 32'h40, 5'd2);
    // Byte and halfword stores, sh at offset 3 wraps into lane 0
    for (int off = 0; off < 4; off++) begin
      add_store(ST_SW, 32'h44, $random(seed), 5'd0, 32'd0, 1'b0);
      add_store(ST_SB, 32'h44 + off, $random(seed), 5'd0, 32'd0, 1'b0);
      add_load(LD_LW, 32'h44, 5'd3);
    end
    for (int off = 0; off < 4; off++) begin
      add_store(ST_SW, 32'h48, $random(seed), 5'd0, 32'd0, 1'b0);
      add_store(ST_SH, 32'h48 + off, $random(seed), 5'd0, 32'd0, 1'b0);
      add_load(LD_LW, 32'h48, 5'd3);
    end
    // Narrow loads, bytes with both sign bit values
    add_store(ST_SW, 32'h4c, 32'h8f7e_a15c, 5'd0, 32'd0, 1'b0);
    for (int off = 0; off < 4; off++) begin
      for (int k = 0; k < 4; k++) add_load(ops[k], 32'h4c + off, 5'd4);
    end
    // Store data forwarded from writeback
    add_alu(5'd7, 32'h0000_0abc);
    add_store(ST_SW, 32'h50, $random(seed), 5'd7, $random(seed), 1'b0);
    add_load(LD_LW, 32'h50, 5'd3);
    // Records under hold are dropped
    add_store(ST_SW, 32'h54, $random(seed), 5'd0, 32'd0, 1'b0);
    add_store(ST_SW, 32'h54, $random(seed), 5'd0, 32'd0, 1'b1);
    add_store(ST_SB, 32'h55, $random(seed), 5'd0, 32'd0, 1'b1);
    add_load(LD_LW, 32'h54, 5'd6);
    // Invalid record neither writes memory nor raises control bits
    add_store(ST_SW, 32'h58, $random(seed), 5'd0, 32'd0, 1'b0);
    add_bubble(32'h58, $random(seed), 5'd5);
    add_load(LD_LW, 32'h58, 5'd6);
  endtask

  initial begin
    seed = 32'h736a;
    bus = 1'b0;
    rst_n = 1'b0;
    hold = 1'b0;
    ex_mem = '0;
    wb_res = 32'd0;
    last_exp = '0;
    build_table();
    for (int c = 0; c < 3; c++) next_fall();
    rst_n = 1'b1;
    next_fall();
    // Nothing accepted yet, record still clear
    check_mem_wb(mem_wb, '0);
    verify_assertions();
    foreach (rows[i]) begin
      hold = rows[i].hold;
      ex_mem = rows[i].em;
      wb_res = rows[i].wb_res;
      next_fall();
      check_word("mem_wb.memres", mem_wb.memres, rows[i].exp.memres);
      check_mem_wb(mem_wb, rows[i].exp);
      verify_assertions();
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: mem_stage.f
+incdir+.
mem_stage_pkg.sv
store_unit.sv
data_ram.sv
load_unit.sv
mem_stage.sv
mem_stage_props.sv
mem_stage_tb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - .
    files:
      - mem_stage_pkg.sv
      - store_unit.sv
      - data_ram.sv
      - load_unit.sv
      - mem_stage.sv
  - target: test
    include_dirs:
      - .
    files:
      - mem_stage_props.sv
      - mem_stage_tb.sv
